// ==== common/riscvPkg.sv ====
// Shared definitions for the RV32 core and its testbench
package riscvPkg;

    // Word address lines on the memory bus
    localparam int addrBits = 15;
    // Data word width
    localparam int dataBits = 32;
    // Sixteen general registers, kept at RAM words 0 to 15
    localparam int regIdxBits = 4;
    // First instruction word after reset (byte address 0x1000)
    localparam int resetPcWord = 'h400;

    // Major opcodes, instruction bits 6 to 2
    localparam logic [4:0] opLoad = 5'b00000;
    localparam logic [4:0] opStore = 5'b01000;
    localparam logic [4:0] opAluImm = 5'b00100;
    localparam logic [4:0] opLui = 5'b01101;

    // ALU codes match funct3 of the immediate ALU group
    localparam logic [2:0] aluAdd = 3'b000;
    localparam logic [2:0] aluXor = 3'b100;
    localparam logic [2:0] aluOr = 3'b110;
    localparam logic [2:0] aluAnd = 3'b111;

    // Sequencer states
    localparam logic [2:0] sIdle = 3'd0;
    localparam logic [2:0] sFetch = 3'd1;
    localparam logic [2:0] sDecode = 3'd2;
    localparam logic [2:0] sRegFetch = 3'd3;
    localparam logic [2:0] sAlu = 3'd4;
    localparam logic [2:0] sDataFetch = 3'd5;
    localparam logic [2:0] sRegStore = 3'd6;

    // One instruction word, seen as I, S or U format
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } uType;
    } riscvInsn;

endpackage

// ==== source/insnDecoder.sv ====
`timescale 1ns/1ps

// Instruction classification and field extraction
module insnDecoder (
    input  riscvPkg::riscvInsn              insn,
    output logic                            isLoad,
    output logic                            isStore,
    output logic                            isAluImm,
    output logic                            isLui,
    output logic                            isByte,
    output logic                            isHalf,
    output logic                            isSigned,
    output logic [riscvPkg::regIdxBits-1:0] rs1Idx,
    output logic [riscvPkg::regIdxBits-1:0] rs2Idx,
    output logic [riscvPkg::regIdxBits-1:0] rdIdx,
    output logic [riscvPkg::dataBits-1:0]   immediate,
    output logic [2:0]                      aluOp
);

    logic [4:0] major;
    logic [2:0] funct3;
    // Full 32-bit encodings have low bits 11
    logic isFull;

    assign major = insn.iType.opcode[6:2];
    assign funct3 = insn.iType.funct3;
    assign isFull = insn.iType.opcode[1:0] == 2'b11;

    // LB LH LW LBU LHU only
    assign isLoad = isFull && major == riscvPkg::opLoad
        && funct3 != 3'b011 && funct3[2:1] != 2'b11;
    // SB SH SW only
    assign isStore = isFull && major == riscvPkg::opStore
        && !funct3[2] && funct3[1:0] != 2'b11;
    // Only ADDI XORI ORI ANDI are supported
    assign isAluImm = isFull && major == riscvPkg::opAluImm
        && (funct3 == riscvPkg::aluAdd || funct3 == riscvPkg::aluXor
            || funct3 == riscvPkg::aluOr || funct3 == riscvPkg::aluAnd);
    assign isLui = isFull && major == riscvPkg::opLui;

    // Word transfer when neither size flag is set
    assign isByte = funct3[1:0] == 2'b00;
    assign isHalf = funct3[1:0] == 2'b01;
    assign isSigned = !funct3[2];

    // rs1 sits at the same bits in I and S formats
    assign rs1Idx = insn.iType.rs1[riscvPkg::regIdxBits-1:0];
    assign rs2Idx = insn.sType.rs2[riscvPkg::regIdxBits-1:0];
    assign rdIdx = insn.iType.rd[riscvPkg::regIdxBits-1:0];
    assign aluOp = funct3;

    always_comb begin
        case (major)
            riscvPkg::opLoad, riscvPkg::opAluImm:
                immediate = {{20{insn.iType.imm[11]}}, insn.iType.imm};
            riscvPkg::opStore:
                immediate = {{20{insn.sType.immHi[6]}}, insn.sType.immHi, insn.sType.immLo};
            riscvPkg::opLui:
                immediate = {insn.uType.imm, 12'b0};
            default:
                immediate = '0;
        endcase
    end

endmodule

// ==== source/riscvAlu.sv ====
`timescale 1ns/1ps

// Immediate-group ALU, the add also forms load and store addresses
module riscvAlu (
    input  logic [2:0]                    aluOp,
    input  logic [riscvPkg::dataBits-1:0] x,
    input  logic [riscvPkg::dataBits-1:0] y,
    output logic [riscvPkg::dataBits-1:0] result
);

    always_comb begin
        case (aluOp)
            riscvPkg::aluAdd: begin
                result = x + y;
            end
            riscvPkg::aluXor: begin
                result = x ^ y;
            end
            riscvPkg::aluOr: begin
                result = x | y;
            end
            riscvPkg::aluAnd: begin
                result = x & y;
            end
            // Codes the decoder never issues
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== source/memLaneAlign.sv ====
`timescale 1ns/1ps

// Byte and half lane handling for loads and stores
module memLaneAlign (
    input  logic [riscvPkg::dataBits-1:0] readWord,
    input  logic [riscvPkg::dataBits-1:0] oldWord,
    input  logic [1:0]                    byteOffset,
    input  logic                          isByte,
    input  logic                          isHalf,
    input  logic                          isSigned,
    output logic [riscvPkg::dataBits-1:0] loadValue,
    output logic [riscvPkg::dataBits-1:0] storeMerged
);

    logic [7:0] loadByte;
    logic [15:0] loadHalf;

    // Lane picked by the offset, half uses bit 1 only
    assign loadByte = readWord[{byteOffset, 3'b000} +: 8];
    assign loadHalf = readWord[{byteOffset[1], 4'b0000} +: 16];

    // Load extraction with sign or zero fill
    always_comb begin
        if (isByte) begin
            loadValue = {{24{isSigned & loadByte[7]}}, loadByte};
        end else if (isHalf) begin
            loadValue = {{16{isSigned & loadHalf[15]}}, loadHalf};
        end else begin
            loadValue = readWord;
        end
    end

    // Store merge, readWord carries rs2 at this point
    always_comb begin
        storeMerged = oldWord;
        if (isByte) begin
            storeMerged[{byteOffset, 3'b000} +: 8] = readWord[7:0];
        end else if (isHalf) begin
            storeMerged[{byteOffset[1], 4'b0000} +: 16] = readWord[15:0];
        end else begin
            // Full word replaces everything
            storeMerged = readWord;
        end
    end

endmodule

// ==== core/coreSequencer.sv ====
`timescale 1ns/1ps

// Multi-cycle control, one instruction at a time over the single bus
module coreSequencer (
    input  logic                            cpuSignals,
    input  logic                            rstN,
    output logic [riscvPkg::addrBits-1:0]   memAddress,
    output logic [riscvPkg::dataBits-1:0]   memWriteData,
    output logic                            memWriteEnable,
    output logic                            memStrobe,
    input  logic [riscvPkg::dataBits-1:0]   memReadData,
    input  logic                            memReady,
    output riscvPkg::riscvInsn              insn,
    input  logic                            isLoad,
    input  logic                            isStore,
    input  logic                            isAluImm,
    input  logic                            isLui,
    input  logic                            isByte,
    input  logic                            isHalf,
    input  logic [riscvPkg::regIdxBits-1:0] rs1Idx,
    input  logic [riscvPkg::regIdxBits-1:0] rs2Idx,
    input  logic [riscvPkg::regIdxBits-1:0] rdIdx,
    input  logic [riscvPkg::dataBits-1:0]   immediate,
    input  logic [2:0]                      aluOpIn,
    output logic [2:0]                      aluOp,
    output logic [riscvPkg::dataBits-1:0]   aluX,
    output logic [riscvPkg::dataBits-1:0]   aluY,
    input  logic [riscvPkg::dataBits-1:0]   aluResult,
    output logic [1:0]                      byteOffset,
    output logic [riscvPkg::dataBits-1:0]   oldWord,
    input  logic [riscvPkg::dataBits-1:0]   loadValue,
    input  logic [riscvPkg::dataBits-1:0]   storeMerged
);

    // Program counter in 32-bit words
    logic [riscvPkg::addrBits-1:0] pc;
    logic [2:0] state;
    // Operand registers, also scratch for store address and lane offset
    logic [riscvPkg::dataBits-1:0] x;
    logic [riscvPkg::dataBits-1:0] y;
    // Set while a store reads its rs2 value
    logic fetchRs2;

    // Register index to RAM word address
    function automatic logic [riscvPkg::addrBits-1:0] regAddr(
        input logic [riscvPkg::regIdxBits-1:0] idx
    );
        regAddr = {{(riscvPkg::addrBits - riscvPkg::regIdxBits){1'b0}}, idx};
    endfunction

    assign aluX = x;
    assign aluY = y;
    // Low address bits saved in x after the address add
    assign byteOffset = x[1:0];
    // Write data register holds the target word between data read and rs2 read
    assign oldWord = memWriteData;

    always_ff @(posedge cpuSignals) begin
        if (!rstN) begin
            pc <= riscvPkg::resetPcWord[riscvPkg::addrBits-1:0];
            state <= riscvPkg::sFetch;
            memStrobe <= 1'b0;
            memWriteEnable <= 1'b0;
            fetchRs2 <= 1'b0;
        end else begin
            case (state)
                riscvPkg::sFetch: begin
                    if (!memStrobe) begin
                        // Start instruction read
                        memAddress <= pc;
                        memWriteEnable <= 1'b0;
                        memStrobe <= 1'b1;
                    end else if (memReady) begin
                        insn <= memReadData;
                        pc <= pc + 1'b1;
                        memStrobe <= 1'b0;
                        state <= riscvPkg::sDecode;
                    end
                end

                riscvPkg::sDecode: begin
                    if (isLui) begin
                        // Upper immediate goes straight to rd
                        memWriteData <= immediate;
                        memAddress <= regAddr(rdIdx);
                        memWriteEnable <= 1'b1;
                        memStrobe <= 1'b1;
                        state <= riscvPkg::sRegStore;
                    end else if (isLoad || isStore || isAluImm) begin
                        memAddress <= regAddr(rs1Idx);
                        memStrobe <= 1'b1;
                        state <= riscvPkg::sRegFetch;
                    end else begin
                        // Unsupported, retire without any write
                        state <= riscvPkg::sIdle;
                    end
                end

                riscvPkg::sRegFetch: begin
                    if (memReady) begin
                        if (fetchRs2) begin
                            // rs2 on the bus, merge its lane into the old word
                            memWriteData <= storeMerged;
                            memAddress <= y[riscvPkg::addrBits-1:0];
                            memWriteEnable <= 1'b1;
                            fetchRs2 <= 1'b0;
                            state <= riscvPkg::sRegStore;
                        end else begin
                            // rs1 value and immediate into the ALU
                            x <= memReadData;
                            y <= immediate;
                            // Loads and stores use the add for the address
                            aluOp <= isAluImm ? aluOpIn : riscvPkg::aluAdd;
                            memStrobe <= 1'b0;
                            state <= riscvPkg::sAlu;
                        end
                    end
                end

                riscvPkg::sAlu: begin
                    if (isAluImm) begin
                        memWriteData <= aluResult;
                        memAddress <= regAddr(rdIdx);
                        memWriteEnable <= 1'b1;
                        state <= riscvPkg::sRegStore;
                    end else begin
                        // Data word read, lane offset kept for the aligner
                        memAddress <= aluResult[riscvPkg::addrBits+1:2];
                        x[1] <= aluResult[1] & (isByte | isHalf);
                        x[0] <= aluResult[0] & isByte;
                        state <= riscvPkg::sDataFetch;
                    end
                    memStrobe <= 1'b1;
                end

                riscvPkg::sDataFetch: begin
                    if (memReady) begin
                        if (isLoad) begin
                            memWriteData <= loadValue;
                            memAddress <= regAddr(rdIdx);
                            memWriteEnable <= 1'b1;
                            state <= riscvPkg::sRegStore;
                        end else begin
                            // Keep target word and its address, then read rs2
                            memWriteData <= memReadData;
                            y <= {{(riscvPkg::dataBits - riscvPkg::addrBits){1'b0}}, memAddress};
                            memAddress <= regAddr(rs2Idx);
                            fetchRs2 <= 1'b1;
                            state <= riscvPkg::sRegFetch;
                        end
                    end
                end

                riscvPkg::sRegStore: begin
                    // Final write of every instruction
                    if (memReady) begin
                        memStrobe <= 1'b0;
                        memWriteEnable <= 1'b0;
                        state <= riscvPkg::sIdle;
                    end
                end

                riscvPkg::sIdle: begin
                    state <= riscvPkg::sFetch;
                end

                default: begin
                    state <= riscvPkg::sIdle;
                end
            endcase
        end
    end

    // Request stays put until the memory answers
    busHold: assert property (@(posedge cpuSignals) disable iff (!rstN)
        memStrobe && !memReady |=> memStrobe && $stable(memAddress)
            && $stable(memWriteEnable) && (!memWriteEnable || $stable(memWriteData)))
        else $error("bus request changed before memReady");

    // No write outside a strobed access
    writeInStrobe: assert property (@(posedge cpuSignals) disable iff (!rstN)
        memWriteEnable |-> memStrobe)
        else $error("memWriteEnable high without memStrobe");

endmodule

// ==== core/riscvCore.sv ====
`timescale 1ns/1ps

// RV32 core top, registers live in the shared RAM
module riscvCore (
    input  logic                          cpuSignals,
    input  logic                          rstN,
    output logic [riscvPkg::addrBits-1:0] memAddress,
    output logic [riscvPkg::dataBits-1:0] memWriteData,
    output logic                          memWriteEnable,
    output logic                          memStrobe,
    input  logic [riscvPkg::dataBits-1:0] memReadData,
    input  logic                          memReady
);

    // Fetched instruction
    riscvPkg::riscvInsn insn;

    // Decoder results
    logic isLoad;
    logic isStore;
    logic isAluImm;
    logic isLui;
    logic isByte;
    logic isHalf;
    logic isSigned;
    logic [riscvPkg::regIdxBits-1:0] rs1Idx;
    logic [riscvPkg::regIdxBits-1:0] rs2Idx;
    logic [riscvPkg::regIdxBits-1:0] rdIdx;
    logic [riscvPkg::dataBits-1:0] immediate;
    logic [2:0] decodedAluOp;

    // ALU path
    logic [2:0] aluOp;
    logic [riscvPkg::dataBits-1:0] aluX;
    logic [riscvPkg::dataBits-1:0] aluY;
    logic [riscvPkg::dataBits-1:0] aluResult;

    // Lane aligner path
    logic [1:0] byteOffset;
    logic [riscvPkg::dataBits-1:0] oldWord;
    logic [riscvPkg::dataBits-1:0] loadValue;
    logic [riscvPkg::dataBits-1:0] storeMerged;

    // Bus outputs come straight from sequencer registers
    coreSequencer sequencer (
        .cpuSignals(cpuSignals), .rstN(rstN),
        .memAddress(memAddress), .memWriteData(memWriteData),
        .memWriteEnable(memWriteEnable), .memStrobe(memStrobe),
        .memReadData(memReadData), .memReady(memReady),
        .insn(insn),
        .isLoad(isLoad), .isStore(isStore), .isAluImm(isAluImm), .isLui(isLui),
        .isByte(isByte), .isHalf(isHalf),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
        .immediate(immediate), .aluOpIn(decodedAluOp),
        .aluOp(aluOp), .aluX(aluX), .aluY(aluY), .aluResult(aluResult),
        .byteOffset(byteOffset), .oldWord(oldWord),
        .loadValue(loadValue), .storeMerged(storeMerged)
    );

    insnDecoder decoder (
        .insn(insn),
        .isLoad(isLoad), .isStore(isStore), .isAluImm(isAluImm), .isLui(isLui),
        .isByte(isByte), .isHalf(isHalf), .isSigned(isSigned),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
        .immediate(immediate), .aluOp(decodedAluOp)
    );

    riscvAlu alu (.aluOp(aluOp), .x(aluX), .y(aluY), .result(aluResult));

    // Read word feeds both load extraction and rs2 lane for stores
    memLaneAlign laneAlign (
        .readWord(memReadData), .oldWord(oldWord), .byteOffset(byteOffset),
        .isByte(isByte), .isHalf(isHalf), .isSigned(isSigned),
        .loadValue(loadValue), .storeMerged(storeMerged)
    );

endmodule

// ==== sim/tbChecker.sv ====
`timescale 1ns/1ps

// Bus monitor, compares every completed write with the expected sequence
module tbChecker (
    input  logic                          cpuSignals,
    input  logic                          rstN,
    input  logic [riscvPkg::addrBits-1:0] memAddress,
    input  logic [riscvPkg::dataBits-1:0] memWriteData,
    input  logic                          memWriteEnable,
    input  logic                          memStrobe,
    input  logic                          memReady,
    output int                            errorCount,
    output int                            writesSeen
);

    localparam int maxWrites = 64;

    // Expected writes in program order
    logic [riscvPkg::addrBits-1:0] expAddr [maxWrites];
    logic [riscvPkg::dataBits-1:0] expData [maxWrites];
    int expCount = 0;
    int errors = 0;
    int seen = 0;
    // First cycle out of reset and first fetch are checked once
    logic resetChecked = 1'b0;
    logic fetchChecked = 1'b0;

    assign errorCount = errors;
    assign writesSeen = seen;

    // Called by the testbench top while it loads the program
    task automatic pushExpected(
        input logic [riscvPkg::addrBits-1:0] addr,
        input logic [riscvPkg::dataBits-1:0] data
    );
        expAddr[expCount] = addr;
        expData[expCount] = data;
        expCount++;
    endtask

    always @(posedge cpuSignals) begin
        if (rstN) begin
            // Bus must be quiet on the first edge after reset
            if (!resetChecked) begin
                if (memStrobe !== 1'b0 || memWriteEnable !== 1'b0) begin
                    $display("Error at %0t ns: strobe %b writeEnable %b right after reset",
                        $time, memStrobe, memWriteEnable);
                    errors++;
                end
                resetChecked = 1'b1;
            end
            // First access is an instruction read at the reset PC
            if (memStrobe === 1'b1 && !fetchChecked) begin
                if (memAddress !== riscvPkg::resetPcWord || memWriteEnable !== 1'b0) begin
                    $display("Error at %0t ns: first access address %h writeEnable %b",
                        $time, memAddress, memWriteEnable);
                    errors++;
                end
                fetchChecked = 1'b1;
            end
            // A write completes when strobe, writeEnable and ready meet
            if (memStrobe === 1'b1 && memWriteEnable === 1'b1 && memReady === 1'b1) begin
                if (seen >= expCount) begin
                    $display("Error at %0t ns: unexpected write to %h data %h",
                        $time, memAddress, memWriteData);
                    errors++;
                end else if (memAddress !== expAddr[seen] || memWriteData !== expData[seen]) begin
                    $display("Error at %0t ns: write %0d got %h <- %h, expected %h <- %h",
                        $time, seen, memAddress, memWriteData, expAddr[seen], expData[seen]);
                    errors++;
                end
                seen++;
            end
        end
    end

endmodule

// ==== sim/tbRiscvCore.sv ====
`timescale 1ns/1ps

// Testbench for riscvCore with a RAM model of random latency
module tbRiscvCore;

    localparam int numEntries = 28;
    localparam int memWords = 1 << riscvPkg::addrBits;
    localparam int cycleLimit = numEntries * 40 + 100;

    logic cpuSignals;
    logic rstN;
    logic [riscvPkg::addrBits-1:0] memAddress;
    logic [riscvPkg::dataBits-1:0] memWriteData;
    logic memWriteEnable;
    logic memStrobe;
    logic [riscvPkg::dataBits-1:0] memReadData;
    logic memReady;

    // One RAM for code, registers and data
    logic [riscvPkg::dataBits-1:0] mem [memWords];

    // Program table with the expected write of each entry
    logic [31:0] progInsn [numEntries];
    logic progWrites [numEntries];
    logic [riscvPkg::addrBits-1:0] progAddr [numEntries];
    logic [31:0] progData [numEntries];
    int entryCount = 0;

    int cycles;
    int waitLeft;
    logic busy;
    int expectCount;
    int errorCount;
    int writesSeen;
    int missing;
    int firstDraw;
    logic timedOut;

    riscvCore i_dut (
        .cpuSignals(cpuSignals), .rstN(rstN),
        .memAddress(memAddress), .memWriteData(memWriteData),
        .memWriteEnable(memWriteEnable), .memStrobe(memStrobe),
        .memReadData(memReadData), .memReady(memReady)
    );

    tbChecker busChecker (
        .cpuSignals(cpuSignals), .rstN(rstN),
        .memAddress(memAddress), .memWriteData(memWriteData),
        .memWriteEnable(memWriteEnable), .memStrobe(memStrobe), .memReady(memReady),
        .errorCount(errorCount), .writesSeen(writesSeen)
    );

    initial cpuSignals = 1'b0;
    always #5 cpuSignals = ~cpuSignals;

    // I-type word for loads and immediate ALU ops
    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] funct3, input logic [4:0] rd, input logic [4:0] major);
        encodeI = {imm, rs1, funct3, rd, major, 2'b11};
    endfunction

    // S-type word, immediate split around rs2 and rs1
    function automatic logic [31:0] encodeS(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] funct3);
        encodeS = {imm[11:5], rs2, rs1, funct3, imm[4:0], riscvPkg::opStore, 2'b11};
    endfunction

    task automatic addEntry(input logic [31:0] insn, input logic writes,
        input logic [riscvPkg::addrBits-1:0] addr, input logic [31:0] data);
        progInsn[entryCount] = insn;
        progWrites[entryCount] = writes;
        progAddr[entryCount] = addr;
        progData[entryCount] = data;
        entryCount++;
    endtask

    // Cycles since reset release
    always @(posedge cpuSignals) begin
        if (rstN) begin
            cycles++;
        end
    end

    // RAM answers 0 to 3 cycles late with a one cycle ready pulse
    always @(posedge cpuSignals) begin
        #1;
        if (memReady) begin
            memReady = 1'b0;
        end else if (rstN && memStrobe) begin
            if (!busy) begin
                busy = 1'b1;
                waitLeft = $urandom % 4;
            end
            if (waitLeft == 0) begin
                if (memWriteEnable) begin
                    mem[memAddress] = memWriteData;
                end else begin
                    memReadData = mem[memAddress];
                end
                memReady = 1'b1;
                busy = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

    initial begin
        rstN = 1'b0;
        memReadData = '0;
        memReady = 1'b0;
        busy = 1'b0;
        waitLeft = 0;
        cycles = 0;
        expectCount = 0;
        timedOut = 1'b0;
        firstDraw = $urandom(94895);

        // Fill never decodes as a 32-bit instruction, low bits stay 00
        for (int a = 0; a < memWords; a++) begin
            mem[a] = {a[14:0], ~a[14:0], 2'b00};
        end
        // x1 load base, x2 store base, x3 ALU source, x4 store data
        mem[0] = 32'h0;
        mem[1] = 32'h0000_2000;
        mem[2] = 32'h0000_2040;
        mem[3] = 32'h1234_5678;
        mem[4] = 32'hDEAD_BEEF;
        mem['h800] = 32'h80FF_7F01;
        for (int a = 'h80F; a <= 'h815; a++) begin
            mem[a] = 32'h1122_3344;
        end

        addEntry({20'hABCDE, 5'd5, riscvPkg::opLui, 2'b11}, 1'b1, 15'd5, 32'hABCD_E000);
        addEntry(encodeI(12'h123, 3, 3'b000, 6, riscvPkg::opAluImm), 1'b1, 15'd6, 32'h1234_579B);
        addEntry(encodeI(12'hFFF, 3, 3'b000, 7, riscvPkg::opAluImm), 1'b1, 15'd7, 32'h1234_5677);
        addEntry(encodeI(12'hF00, 3, 3'b100, 8, riscvPkg::opAluImm), 1'b1, 15'd8, 32'hEDCB_A978);
        addEntry(encodeI(12'h0F0, 3, 3'b110, 9, riscvPkg::opAluImm), 1'b1, 15'd9, 32'h1234_56F8);
        addEntry(encodeI(12'hFF0, 3, 3'b111, 10, riscvPkg::opAluImm), 1'b1, 15'd10, 32'h1234_5670);
        addEntry(encodeI(12'h7FF, 3, 3'b111, 11, riscvPkg::opAluImm), 1'b1, 15'd11, 32'h0000_0678);
        // SLTI, retires with no write
        addEntry(encodeI(12'h001, 3, 3'b010, 12, riscvPkg::opAluImm), 1'b0, '0, '0);
        // LB and LBU over all four lanes of 0x80FF7F01
        addEntry(encodeI(12'd0, 1, 3'b000, 5, riscvPkg::opLoad), 1'b1, 15'd5, 32'h0000_0001);
        addEntry(encodeI(12'd1, 1, 3'b000, 6, riscvPkg::opLoad), 1'b1, 15'd6, 32'h0000_007F);
        addEntry(encodeI(12'd2, 1, 3'b000, 7, riscvPkg::opLoad), 1'b1, 15'd7, 32'hFFFF_FFFF);
        addEntry(encodeI(12'd3, 1, 3'b000, 8, riscvPkg::opLoad), 1'b1, 15'd8, 32'hFFFF_FF80);
        addEntry(encodeI(12'd0, 1, 3'b100, 9, riscvPkg::opLoad), 1'b1, 15'd9, 32'h0000_0001);
        addEntry(encodeI(12'd1, 1, 3'b100, 10, riscvPkg::opLoad), 1'b1, 15'd10, 32'h0000_007F);
        addEntry(encodeI(12'd2, 1, 3'b100, 11, riscvPkg::opLoad), 1'b1, 15'd11, 32'h0000_00FF);
        addEntry(encodeI(12'd3, 1, 3'b100, 12, riscvPkg::opLoad), 1'b1, 15'd12, 32'h0000_0080);
        // Halves, then the full word
        addEntry(encodeI(12'd0, 1, 3'b001, 13, riscvPkg::opLoad), 1'b1, 15'd13, 32'h0000_7F01);
        addEntry(encodeI(12'd2, 1, 3'b001, 14, riscvPkg::opLoad), 1'b1, 15'd14, 32'hFFFF_80FF);
        addEntry(encodeI(12'd0, 1, 3'b101, 15, riscvPkg::opLoad), 1'b1, 15'd15, 32'h0000_7F01);
        addEntry(encodeI(12'd2, 1, 3'b101, 5, riscvPkg::opLoad), 1'b1, 15'd5, 32'h0000_80FF);
        addEntry(encodeI(12'd0, 1, 3'b010, 6, riscvPkg::opLoad), 1'b1, 15'd6, 32'h80FF_7F01);
        // Stores of 0xDEADBEEF into words holding 0x11223344
        addEntry(encodeS(12'd0, 4, 2, 3'b000), 1'b1, 15'h810, 32'h1122_33EF);
        addEntry(encodeS(12'd5, 4, 2, 3'b000), 1'b1, 15'h811, 32'h1122_EF44);
        addEntry(encodeS(12'd10, 4, 2, 3'b000), 1'b1, 15'h812, 32'h11EF_3344);
        addEntry(encodeS(12'd15, 4, 2, 3'b000), 1'b1, 15'h813, 32'hEF22_3344);
        addEntry(encodeS(12'd16, 4, 2, 3'b001), 1'b1, 15'h814, 32'h1122_BEEF);
        addEntry(encodeS(12'd22, 4, 2, 3'b001), 1'b1, 15'h815, 32'hBEEF_3344);
        addEntry(encodeS(12'hFFC, 4, 2, 3'b010), 1'b1, 15'h80F, 32'hDEAD_BEEF);

        // Program goes in from the reset PC, expected writes to the checker
        for (int i = 0; i < entryCount; i++) begin
            mem[riscvPkg::resetPcWord + i] = progInsn[i];
            if (progWrites[i]) begin
                busChecker.pushExpected(progAddr[i], progData[i]);
                expectCount++;
            end
        end

        repeat (10) @(posedge cpuSignals);
        #1;
        rstN = 1'b1;

        while (writesSeen < expectCount && cycles < cycleLimit) begin
            @(posedge cpuSignals);
            #1;
        end
        timedOut = cycles >= cycleLimit;
        // A few more cycles catch any stray write
        if (!timedOut) begin
            repeat (20) @(posedge cpuSignals);
            #1;
        end

        missing = expectCount - writesSeen;
        if (missing < 0) begin
            missing = 0;
        end
        if (timedOut) begin
            $display("Core stalled: only %0d of %0d writes after %0d cycles",
                writesSeen, expectCount, cycles);
        end
        $display("Summary: %0d errors, %0d missing writes", errorCount, missing);
        if (!timedOut && errorCount == 0 && missing == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/riscvPkg.sv
source/insnDecoder.sv
source/riscvAlu.sv
source/memLaneAlign.sv
core/coreSequencer.sv
core/riscvCore.sv
sim/tbChecker.sv
sim/tbRiscvCore.sv
